/* source/i2c_pkg.sv */
package i2c_pkg;

	////////////////////////////////////////
	// widths
	////////////////////////////////////////

	typedef logic [7:0] i2c_byte_t;
	typedef logic [2:0] reg_addr_t;

	localparam int BITS_PER_BYTE = 8;

	////////////////////////////////////////
	// host register map
	////////////////////////////////////////

	localparam reg_addr_t REG_CONTROL    = 3'd0;
	localparam reg_addr_t REG_SLAVE_ADDR = 3'd1;
	localparam reg_addr_t REG_TARGET_REG = 3'd2;
	localparam reg_addr_t REG_DATA       = 3'd3;

	// only the go bit of the control byte does anything
	localparam int CTRL_GO_BIT = 0;

	// bit engine commands
	typedef enum logic [1:0] {
		op_start,
		op_byte,
		op_stop
	} bit_op_t;

	typedef enum logic [2:0] {
		seq_idle,
		seq_start,
		seq_addr,
		seq_reg,
		seq_data,
		seq_stop
	} seq_state_t;

endpackage

/* source/i2c_if.sv */
`timescale 1ns/1ns

// transfer request from register bank to sequencer
interface xfer_if;
	import i2c_pkg::*;

	logic      go;
	i2c_byte_t slave_addr;
	i2c_byte_t target_reg;
	i2c_byte_t data;

	modport bank (output go, output slave_addr, output target_reg, output data);
	modport seq (input go, input slave_addr, input target_reg, input data);

endinterface

// one command at a time from sequencer to bit engine
interface bit_cmd_if;
	import i2c_pkg::*;

	logic      cmd_valid;
	bit_op_t   cmd_op;
	i2c_byte_t cmd_byte;
	logic      done;
	logic      acked;

	modport seq (output cmd_valid, output cmd_op, output cmd_byte, input done, input acked);
	modport engine (input cmd_valid, input cmd_op, input cmd_byte, output done, output acked);

endinterface

/* source/i2c_reg_bank.sv */
`timescale 1ns/1ns

module i2c_reg_bank
(
	input  logic              clk_div_2,
	input  logic              reset_n,
	input  logic              write,
	input  i2c_pkg::reg_addr_t address,
	input  i2c_pkg::i2c_byte_t writedata,
	xfer_if.bank              xfer
);
	import i2c_pkg::*;

	logic go_write;

	// control write with the go bit set
	assign go_write = write && (address == REG_CONTROL) && writedata[CTRL_GO_BIT];

	////////////////////////////////////////
	// go strobe
	////////////////////////////////////////

	always_ff @(posedge clk_div_2)
	begin
		if (!reset_n)
		begin
			xfer.go <= 1'b0;
		end
		else
		begin
			xfer.go <= go_write;
		end
	end

	////////////////////////////////////////
	// byte registers
	////////////////////////////////////////

	always_ff @(posedge clk_div_2)
	begin
		if (!reset_n)
		begin
			xfer.slave_addr <= '0;
			xfer.target_reg <= '0;
			xfer.data <= '0;
		end
		else if (write)
		begin
			case (address)
				REG_SLAVE_ADDR: xfer.slave_addr <= writedata;
				REG_TARGET_REG: xfer.target_reg <= writedata;
				REG_DATA:       xfer.data <= writedata;
				default:        ;
			endcase
		end
	end

endmodule

/* source/i2c_byte_sequencer.sv */
`timescale 1ns/1ns

module i2c_byte_sequencer
(
	input  logic    clk_div_2,
	input  logic    reset_n,
	xfer_if.seq     xfer,
	bit_cmd_if.seq  bit_cmd,
	output logic    ready,
	output logic    success_out
);
	import i2c_pkg::*;

	seq_state_t state;
	logic       accept;
	logic       all_acked;
	i2c_byte_t  addr_q;
	i2c_byte_t  reg_q;
	i2c_byte_t  data_q;

	// go is dropped unless idle
	assign accept = (state == seq_idle) && xfer.go;

	////////////////////////////////////////
	// transfer FSM
	////////////////////////////////////////

	always_ff @(posedge clk_div_2)
	begin
		if (!reset_n)
		begin
			state <= seq_idle;
			ready <= 1'b1;
			success_out <= 1'b0;
			all_acked <= 1'b0;
			bit_cmd.cmd_valid <= 1'b0;
			bit_cmd.cmd_op <= op_start;
		end
		else
		begin
			bit_cmd.cmd_valid <= 1'b0;
			case (state)
				seq_idle:
				begin
					if (accept)
					begin
						state <= seq_start;
						ready <= 1'b0;
						success_out <= 1'b0;
						all_acked <= 1'b0;
						bit_cmd.cmd_valid <= 1'b1;
						bit_cmd.cmd_op <= op_start;
					end
				end
				seq_start:
				begin
					if (bit_cmd.done)
					begin
						state <= seq_addr;
						bit_cmd.cmd_valid <= 1'b1;
						bit_cmd.cmd_op <= op_byte;
					end
				end
				seq_addr, seq_reg:
				begin
					if (bit_cmd.done)
					begin
						bit_cmd.cmd_valid <= 1'b1;
						// nack goes straight to stop
						if (bit_cmd.acked)
						begin
							state <= (state == seq_addr) ? seq_reg : seq_data;
							bit_cmd.cmd_op <= op_byte;
						end
						else
						begin
							state <= seq_stop;
							bit_cmd.cmd_op <= op_stop;
						end
					end
				end
				seq_data:
				begin
					if (bit_cmd.done)
					begin
						state <= seq_stop;
						all_acked <= bit_cmd.acked;
						bit_cmd.cmd_valid <= 1'b1;
						bit_cmd.cmd_op <= op_stop;
					end
				end
				seq_stop:
				begin
					if (bit_cmd.done)
					begin
						state <= seq_idle;
						ready <= 1'b1;
						success_out <= all_acked;
					end
				end
				default: state <= seq_idle;
			endcase
		end
	end

	////////////////////////////////////////
	// transfer bytes and command payload
	////////////////////////////////////////

	always_ff @(posedge clk_div_2)
	begin
		// snapshot so host writes cannot touch a transfer in flight
		if (accept)
		begin
			addr_q <= xfer.slave_addr;
			reg_q <= xfer.target_reg;
			data_q <= xfer.data;
		end
		if (bit_cmd.done)
		begin
			case (state)
				seq_start: bit_cmd.cmd_byte <= addr_q;
				seq_addr:  bit_cmd.cmd_byte <= reg_q;
				seq_reg:   bit_cmd.cmd_byte <= data_q;
				default:   ;
			endcase
		end
	end

endmodule

/* source/i2c_bit_engine.sv */
`timescale 1ns/1ns

module i2c_bit_engine
#(
	parameter int clks_per_quarter = 2
)
(
	input  logic       clk_div_2,
	input  logic       reset_n,
	bit_cmd_if.engine  bit_cmd,
	input  logic       sda_in,
	output logic       sda,
	output logic       sda_oe,
	output logic       scl_out
);
	import i2c_pkg::*;

	localparam int cnt_w = (clks_per_quarter > 1) ? $clog2(clks_per_quarter) : 1;
	localparam logic [cnt_w-1:0] q_last = cnt_w'(clks_per_quarter - 1);
	localparam logic [3:0] ack_slot = 4'(BITS_PER_BYTE);

	logic             busy;
	bit_op_t          op;
	logic [cnt_w-1:0] qcnt;
	logic [1:0]       qidx;
	logic [3:0]       bcnt;
	i2c_byte_t        shift_q;
	logic             scl_hold;
	logic             sda_hold;
	logic             oe_hold;
	logic             quarter_end;

	assign quarter_end = (qcnt == q_last);

	////////////////////////////////////////
	// counters and handshake
	////////////////////////////////////////

	always_ff @(posedge clk_div_2)
	begin
		if (!reset_n)
		begin
			busy <= 1'b0;
			op <= op_start;
			qcnt <= '0;
			qidx <= '0;
			bcnt <= '0;
			bit_cmd.done <= 1'b0;
			bit_cmd.acked <= 1'b0;
		end
		else
		begin
			bit_cmd.done <= 1'b0;
			if (!busy)
			begin
				if (bit_cmd.cmd_valid)
				begin
					busy <= 1'b1;
					op <= bit_cmd.cmd_op;
					qcnt <= '0;
					qidx <= '0;
					bcnt <= '0;
				end
			end
			else if (!quarter_end)
			begin
				qcnt <= qcnt + 1'b1;
			end
			else
			begin
				qcnt <= '0;
				qidx <= qidx + 1'b1;
				// ack sampled at end of first high quarter
				if (op == op_byte && bcnt == ack_slot && qidx == 2'd1)
					bit_cmd.acked <= ~sda_in;
				if (qidx == 2'd3)
				begin
					if (op == op_byte && bcnt != ack_slot)
					begin
						bcnt <= bcnt + 1'b1;
					end
					else
					begin
						busy <= 1'b0;
						bit_cmd.done <= 1'b1;
					end
				end
			end
		end
	end

	// msb first with the next bit at slot end
	always_ff @(posedge clk_div_2)
	begin
		if (!busy && bit_cmd.cmd_valid)
			shift_q <= bit_cmd.cmd_byte;
		else if (busy && quarter_end && qidx == 2'd3)
			shift_q <= {shift_q[BITS_PER_BYTE-2:0], 1'b0};
	end

	////////////////////////////////////////
	// line levels
	////////////////////////////////////////

	always_comb
	begin
		scl_out = scl_hold;
		sda = sda_hold;
		sda_oe = oe_hold;
		if (busy)
		begin
			sda_oe = 1'b1;
			case (op)
				op_start:
				begin
					scl_out = (qidx < 2'd2);
					sda = (qidx == 2'd0);
				end
				op_byte:
				begin
					scl_out = (qidx == 2'd1) || (qidx == 2'd2);
					if (bcnt == ack_slot)
					begin
						sda_oe = 1'b0;
						sda = 1'b0;
					end
					else
						sda = shift_q[BITS_PER_BYTE-1];
				end
				op_stop:
				begin
					scl_out = (qidx != 2'd0);
					sda = (qidx >= 2'd2);
				end
				default: sda_oe = oe_hold;
			endcase
		end
	end

	// lines keep their last level between commands
	always_ff @(posedge clk_div_2)
	begin
		if (!reset_n)
		begin
			scl_hold <= 1'b1;
			sda_hold <= 1'b1;
			oe_hold <= 1'b1;
		end
		else if (busy)
		begin
			scl_hold <= scl_out;
			sda_hold <= sda;
			oe_hold <= sda_oe;
		end
	end

endmodule

/* source/i2c_write_master.sv */
`timescale 1ns/1ns

module i2c_write_master
#(
	parameter int clks_per_quarter = 2
)
(
	input  logic               clk_div_2,
	input  logic               reset_n,
	input  logic               write,
	input  i2c_pkg::reg_addr_t address,
	input  i2c_pkg::i2c_byte_t writedata,
	input  logic               sda_in,
	output logic               sda,
	output logic               sda_oe,
	output logic               scl_out,
	output logic               ready,
	output logic               success_out
);

	xfer_if    xfer ();
	bit_cmd_if bit_cmd ();

	////////////////////////////////////////
	// register bank, sequencer, bit engine
	////////////////////////////////////////

	i2c_reg_bank u_reg_bank (
		.clk_div_2 (clk_div_2),
		.reset_n   (reset_n),
		.write     (write),
		.address   (address),
		.writedata (writedata),
		.xfer      (xfer.bank)
	);

	i2c_byte_sequencer u_sequencer (
		.clk_div_2   (clk_div_2),
		.reset_n     (reset_n),
		.xfer        (xfer.seq),
		.bit_cmd     (bit_cmd.seq),
		.ready       (ready),
		.success_out (success_out)
	);

	i2c_bit_engine #(
		.clks_per_quarter (clks_per_quarter)
	) u_bit_engine (
		.clk_div_2 (clk_div_2),
		.reset_n   (reset_n),
		.bit_cmd   (bit_cmd.engine),
		.sda_in    (sda_in),
		.sda       (sda),
		.sda_oe    (sda_oe),
		.scl_out   (scl_out)
	);

endmodule

/* bench/tb_clock.sv */
`timescale 1ns/1ns

module tb_clock
#(
	parameter int period_ns = 4
)
(
	output logic clk
);

	initial
	begin
		clk = 1'b0;
		forever #(period_ns / 2) clk = ~clk;
	end

endmodule

/* bench/i2c_slave_model.sv */
`timescale 1ns/1ns

module i2c_slave_model
(
	input  logic       clk_div_2,
	input  logic       reset_n,
	input  logic       scl,
	input  logic       sda_line,
	input  logic [1:0] nack_pos,
	output logic       pull_low,
	output int         start_count,
	output int         stop_count,
	output int         rx_count
);

	logic [7:0] rx_log [0:63];
	logic [7:0] shift;
	logic       in_frame;
	logic       prev_scl;
	logic       prev_sda;
	int         bit_cnt;
	int         byte_idx;

	// lines sampled mid cycle away from the master's edges
	always @(negedge clk_div_2)
	begin
		if (!reset_n)
		begin
			pull_low <= 1'b0;
			start_count <= 0;
			stop_count <= 0;
			rx_count <= 0;
			in_frame <= 1'b0;
			prev_scl <= 1'b1;
			prev_sda <= 1'b1;
			bit_cnt <= 0;
			byte_idx <= 0;
		end
		else
		begin
			prev_scl <= scl;
			prev_sda <= sda_line;
			if (scl && prev_scl && prev_sda && !sda_line)
			begin
				start_count <= start_count + 1;
				in_frame <= 1'b1;
				bit_cnt <= 0;
				byte_idx <= 0;
			end
			else if (scl && prev_scl && !prev_sda && sda_line)
			begin
				stop_count <= stop_count + 1;
				in_frame <= 1'b0;
				pull_low <= 1'b0;
			end
			else if (in_frame && scl && !prev_scl && bit_cnt < 8)
			begin
				shift <= {shift[6:0], sda_line};
				bit_cnt <= bit_cnt + 1;
				if (bit_cnt == 7)
				begin
					rx_log[rx_count[5:0]] <= {shift[6:0], sda_line};
					rx_count <= rx_count + 1;
				end
			end
			else if (in_frame && !scl && prev_scl)
			begin
				// ack slot follows the eighth bit
				if (bit_cnt == 8)
				begin
					pull_low <= (byte_idx != int'(nack_pos));
					bit_cnt <= 9;
				end
				else if (bit_cnt == 9)
				begin
					pull_low <= 1'b0;
					bit_cnt <= 0;
					byte_idx <= byte_idx + 1;
				end
			end
		end
	end

endmodule

/* bench/i2c_tb.sv */
`timescale 1ns/1ns

module i2c_tb;
	import i2c_pkg::*;

	localparam int clks_per_quarter = 2;
	localparam int n_tests = 9;
	localparam int mode_plain = 0;
	localparam int mode_busy_go = 1;
	localparam int mode_late_data = 2;
	localparam int mode_no_go = 3;
	localparam logic [1:0] nack_none = 2'd3;

	logic       clk_div_2;
	logic       reset_n;
	logic       write;
	reg_addr_t  address;
	i2c_byte_t  writedata;
	logic       sda_in;
	logic       sda;
	logic       sda_oe;
	logic       scl_out;
	logic       ready;
	logic       success_out;
	logic       sda_line;
	logic       pull_low;
	logic [1:0] nack_pos;
	int         start_count;
	int         stop_count;
	int         rx_count;

	string      t_name [n_tests];
	i2c_byte_t  t_addr [n_tests];
	i2c_byte_t  t_reg [n_tests];
	i2c_byte_t  t_data [n_tests];
	logic       t_write_data [n_tests];
	int         t_mode [n_tests];
	logic [1:0] t_nack [n_tests];
	int         t_bytes [n_tests];
	logic       t_success [n_tests];
	i2c_byte_t  t_late [n_tests];

	int seed = 32'h2d5e;
	int errors = 0;
	int checks = 0;
	int i;

	// open drain bus with pull-up
	assign sda_line = (sda_oe ? sda : 1'b1) & ~pull_low;
	assign sda_in = sda_line;

	tb_clock #(.period_ns(4)) clock_gen (.clk(clk_div_2));

	i2c_write_master #(.clks_per_quarter(clks_per_quarter)) UUT (
		.clk_div_2   (clk_div_2),
		.reset_n     (reset_n),
		.write       (write),
		.address     (address),
		.writedata   (writedata),
		.sda_in      (sda_in),
		.sda         (sda),
		.sda_oe      (sda_oe),
		.scl_out     (scl_out),
		.ready       (ready),
		.success_out (success_out)
	);

	i2c_slave_model slave (
		.clk_div_2   (clk_div_2),
		.reset_n     (reset_n),
		.scl         (scl_out),
		.sda_line    (sda_line),
		.nack_pos    (nack_pos),
		.pull_low    (pull_low),
		.start_count (start_count),
		.stop_count  (stop_count),
		.rx_count    (rx_count)
	);

	////////////////////////////////////////
	// helpers
	////////////////////////////////////////

	task automatic set_row(input int n, input string name, input i2c_byte_t a,
		input i2c_byte_t r, input i2c_byte_t d, input logic wd, input int mode,
		input logic [1:0] nack, input int nbytes, input logic succ, input i2c_byte_t late);
		t_name[n] = name;
		t_addr[n] = a;
		t_reg[n] = r;
		t_data[n] = d;
		t_write_data[n] = wd;
		t_mode[n] = mode;
		t_nack[n] = nack;
		t_bytes[n] = nbytes;
		t_success[n] = succ;
		t_late[n] = late;
	endtask

	task automatic check_equal(input string test, input string what,
		input int expected, input int actual);
		checks++;
		assert (expected == actual)
		else
		begin
			errors++;
			$display("ERR %s: %s expected 0x%0h actual 0x%0h", test, what, expected, actual);
		end
	endtask

	task automatic host_write(input reg_addr_t a, input i2c_byte_t d);
		@(posedge clk_div_2);
		#1;
		write = 1'b1;
		address = a;
		writedata = d;
		@(posedge clk_div_2);
		#1;
		write = 1'b0;
	endtask

	task automatic run_row(input int n);
		int starts0;
		int stops0;
		int rx0;
		int guard;
		int held;
		int exp_xfers;
		i2c_byte_t sent [3];
		sent[0] = t_addr[n];
		sent[1] = t_reg[n];
		sent[2] = t_data[n];
		held = 1;
		exp_xfers = (t_mode[n] == mode_no_go) ? 0 : 1;
		nack_pos = t_nack[n];
		starts0 = start_count;
		stops0 = stop_count;
		rx0 = rx_count;
		host_write(REG_SLAVE_ADDR, t_addr[n]);
		host_write(REG_TARGET_REG, t_reg[n]);
		if (t_write_data[n])
			host_write(REG_DATA, t_data[n]);
		if (t_mode[n] == mode_no_go)
		begin
			host_write(REG_CONTROL, 8'h02);
			repeat (20)
			begin
				@(negedge clk_div_2);
				if (!ready)
					held = 0;
			end
			check_equal(t_name[n], "ready held", 1, held);
		end
		else
		begin
			host_write(REG_CONTROL, 8'h01);
			guard = 0;
			while (ready && guard < 8)
			begin
				@(negedge clk_div_2);
				guard++;
			end
			checks++;
			assert (!ready)
			else
			begin
				errors++;
				$display("%s: ready did not fall after the go write", t_name[n]);
			end
			if (t_mode[n] == mode_busy_go)
				host_write(REG_CONTROL, 8'h01);
			if (t_mode[n] == mode_late_data)
				host_write(REG_DATA, t_late[n]);
			while (!ready)
				@(negedge clk_div_2);
		end
		@(negedge clk_div_2);
		check_equal(t_name[n], "starts", exp_xfers, start_count - starts0);
		check_equal(t_name[n], "stops", exp_xfers, stop_count - stops0);
		check_equal(t_name[n], "byte count", t_bytes[n], rx_count - rx0);
		for (int b = 0; b < t_bytes[n] && b < 3; b++)
			check_equal(t_name[n], "byte", sent[b], slave.rx_log[(rx0 + b) % 64]);
		check_equal(t_name[n], "success_out", t_success[n], success_out);
		check_equal(t_name[n], "ready", 1, ready);
	endtask

	////////////////////////////////////////
	// main sequence
	////////////////////////////////////////

	initial
	begin
		int r;
		write = 1'b0;
		address = '0;
		writedata = '0;
		reset_n = 1'b0;
		nack_pos = nack_none;

		set_row(0, "all_acked", 8'hA0, 8'h10, 8'h5A, 1'b1, mode_plain, nack_none, 3, 1'b1, 8'h00);
		set_row(1, "nack_addr", 8'hA2, 8'h11, 8'h33, 1'b1, mode_plain, 2'd0, 1, 1'b0, 8'h00);
		r = $random(seed);
		set_row(2, "rand_acked", 8'h4E, 8'h07, r[7:0], 1'b1, mode_plain, nack_none, 3, 1'b1, 8'h00);
		set_row(3, "nack_reg", 8'hA4, 8'h22, 8'h81, 1'b1, mode_plain, 2'd1, 2, 1'b0, 8'h00);
		set_row(4, "busy_go", 8'h3A, 8'hF0, 8'h0F, 1'b1, mode_busy_go, nack_none, 3, 1'b1, 8'h00);
		r = $random(seed);
		set_row(5, "nack_data", 8'hA6, 8'h33, r[7:0], 1'b1, mode_plain, 2'd2, 3, 1'b0, 8'h00);
		set_row(6, "late_data", 8'h90, 8'h44, 8'h3C, 1'b1, mode_late_data, nack_none, 3, 1'b1,
			8'hC3);
		// data register keeps the late write
		set_row(7, "next_data", 8'h92, 8'h45, 8'hC3, 1'b0, mode_plain, nack_none, 3, 1'b1, 8'h00);
		set_row(8, "go_clear", 8'h94, 8'h46, 8'h00, 1'b0, mode_no_go, nack_none, 0, 1'b1, 8'h00);

		repeat (10) @(posedge clk_div_2);
		#1;
		reset_n = 1'b1;
		@(negedge clk_div_2);
		check_equal("reset", "ready", 1, ready);
		check_equal("reset", "success_out", 0, success_out);
		check_equal("reset", "scl_out", 1, scl_out);
		check_equal("reset", "sda", 1, sda);
		check_equal("reset", "sda_oe", 1, sda_oe);

		for (i = 0; i < n_tests; i++)
			run_row(i);

		$display("tests: %0d, checks: %0d, errors: %0d", n_tests, checks, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	// watchdog
	initial
	begin
		repeat (n_tests * (40 * 4 * clks_per_quarter + 50)) @(posedge clk_div_2);
		$display("timeout: the tests did not finish in the allowed number of cycles");
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

/* tb.f */
source/i2c_pkg.sv
source/i2c_if.sv
source/i2c_reg_bank.sv
source/i2c_byte_sequencer.sv
source/i2c_bit_engine.sv
source/i2c_write_master.sv
bench/tb_clock.sv
bench/i2c_slave_model.sv
bench/i2c_tb.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module i2c_tb -o i2c_tb_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

output="$(./obj_dir/i2c_tb_sim)"
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qxF "PASS: all tests"; then
	exit 0
fi
exit 1
